// File: lc3b_types.sv
`default_nettype none

package lc3b_types;

	////////////////////////////////////////////////////////////
	// data and register index types.
	////////////////////////////////////////////////////////////

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  lc3b_reg;

	// opcode encodings of the lc-3b isa.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	// second alu operand source.
	typedef enum logic [1:0] {
		reg_sr2,
		imm5,
		shamt4
	} lc3b_alumux_sel;

	typedef enum logic {
		wb_alu,
		wb_lea
	} lc3b_wbmux_sel;

	////////////////////////////////////////////////////////////
	// control word and stage payloads.
	////////////////////////////////////////////////////////////

	typedef struct packed {
		lc3b_opcode     opcode;
		lc3b_aluop      aluop;
		lc3b_alumux_sel alumux_sel;
		lc3b_wbmux_sel  wbmux_sel;
		logic           regfile_load;
		logic           cc_load;
		logic           legal;
	} lc3b_control;

	typedef struct packed {
		lc3b_word instr;
		lc3b_word pc_next;
	} lc3b_if_id;

	typedef struct packed {
		lc3b_control ctrl;
		lc3b_reg     dest;
		lc3b_word    a;
		lc3b_word    b;
		lc3b_word    imm;
		logic [3:0]  shamt;
		lc3b_word    lea_addr;
	} lc3b_id_ex;

	typedef struct packed {
		lc3b_control ctrl;
		lc3b_reg     dest;
		lc3b_word    result;
	} lc3b_ex_wb;

	////////////////////////////////////////////////////////////
	// host address map and constants.
	////////////////////////////////////////////////////////////

	localparam logic [7:0]  addr_instr       = 8'h00;
	localparam logic [7:0]  addr_status      = 8'h04;
	localparam logic [7:0]  addr_reg_base    = 8'h20;
	localparam lc3b_word    pc_reset         = 16'h3000;
	localparam logic [1:0]  axil_resp_okay   = 2'b00;
	localparam logic [1:0]  axil_resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: lc3b_control_gen.sv
`default_nettype none

module lc3b_control_gen import lc3b_types::*; (
	input  lc3b_opcode  opcode,
	input  logic [11:0] ir_bits,
	output lc3b_control ctrl
);

	always_comb begin
		// defaults describe an instruction that changes nothing.
		ctrl.opcode       = opcode;
		ctrl.aluop        = alu_add;
		ctrl.alumux_sel   = reg_sr2;
		ctrl.wbmux_sel    = wb_alu;
		ctrl.regfile_load = 1'b0;
		ctrl.cc_load      = 1'b0;
		ctrl.legal        = 1'b0;

		case (opcode)
			op_add: begin
				// bit 5 picks the immediate form.
				if (ir_bits[5])
					ctrl.alumux_sel = imm5;
				else
					ctrl.alumux_sel = reg_sr2;
				ctrl.regfile_load = 1'b1;
				ctrl.cc_load      = 1'b1;
				ctrl.legal        = 1'b1;
			end
			op_and: begin
				if (ir_bits[5])
					ctrl.alumux_sel = imm5;
				else
					ctrl.alumux_sel = reg_sr2;
				ctrl.aluop        = alu_and;
				ctrl.regfile_load = 1'b1;
				ctrl.cc_load      = 1'b1;
				ctrl.legal        = 1'b1;
			end
			op_not: begin
				ctrl.aluop        = alu_not;
				ctrl.regfile_load = 1'b1;
				ctrl.cc_load      = 1'b1;
				ctrl.legal        = 1'b1;
			end
			op_shf: begin
				// bit 4 is direction, bit 5 arithmetic for right shifts.
				ctrl.alumux_sel = shamt4;
				if (!ir_bits[4])
					ctrl.aluop = alu_sll;
				else if (!ir_bits[5])
					ctrl.aluop = alu_srl;
				else
					ctrl.aluop = alu_sra;
				ctrl.regfile_load = 1'b1;
				ctrl.cc_load      = 1'b1;
				ctrl.legal        = 1'b1;
			end
			op_lea: begin
				ctrl.wbmux_sel    = wb_lea;
				ctrl.regfile_load = 1'b1;
				ctrl.cc_load      = 1'b1;
				ctrl.legal        = 1'b1;
			end
			default: begin
				// branches, jumps, traps and memory ops retire as no-ops.
				ctrl.legal = 1'b0;
			end
		endcase
	end

endmodule : lc3b_control_gen

`default_nettype wire

// File: lc3b_stage_reg.sv
`default_nettype none

module lc3b_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     valid_in,
	input  payload_t data_in,
	output logic     valid,
	output payload_t data
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid <= 1'b0;
		else
			valid <= valid_in;
	end

	// payload only moves with a valid instruction.
	always_ff @(posedge clk) begin
		if (valid_in)
			data <= data_in;
	end

endmodule : lc3b_stage_reg

`default_nettype wire

// File: lc3b_regfile.sv
`default_nettype none

module lc3b_regfile import lc3b_types::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     load,
	input  lc3b_reg  dest,
	input  lc3b_word wdata,
	input  lc3b_reg  sr1,
	input  lc3b_reg  sr2,
	input  lc3b_reg  host_sel,
	output lc3b_word sr1_data,
	output lc3b_word sr2_data,
	output lc3b_word host_data
);

	lc3b_word regs [8];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (load) begin
			regs[dest] <= wdata;
		end
	end

	// write-first: a same-cycle write is seen by decode.
	assign sr1_data = (load && dest == sr1) ? wdata : regs[sr1];
	assign sr2_data = (load && dest == sr2) ? wdata : regs[sr2];

	assign host_data = regs[host_sel];

endmodule : lc3b_regfile

`default_nettype wire

// File: lc3b_alu.sv
`default_nettype none

module lc3b_alu import lc3b_types::*; (
	input  lc3b_aluop      aluop,
	input  lc3b_alumux_sel alumux_sel,
	input  lc3b_word       a,
	input  lc3b_word       b,
	input  lc3b_word       imm,
	input  logic [3:0]     shamt,
	output lc3b_word       result
);

	lc3b_word op2;

	// second operand mux.
	always_comb begin
		case (alumux_sel)
			imm5:    op2 = imm;
			shamt4:  op2 = {12'h000, shamt};
			default: op2 = b;
		endcase
	end

	always_comb begin
		case (aluop)
			alu_add:  result = a + op2;
			alu_and:  result = a & op2;
			alu_not:  result = ~a;
			alu_pass: result = a;
			alu_sll:  result = a << op2[3:0];
			alu_srl:  result = a >> op2[3:0];
			alu_sra:  result = $signed(a) >>> op2[3:0];
			default:  result = a;
		endcase
	end

endmodule : lc3b_alu

`default_nettype wire

// File: lc3b_axil_port.sv
`default_nettype none

module lc3b_axil_port import lc3b_types::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [7:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [7:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output logic        instr_valid,
	output lc3b_word    instr,
	output lc3b_reg     host_rd_addr,
	input  lc3b_word    host_rd_data,
	input  logic [31:0] status
);

	logic instr_hit;
	logic reg_hit;
	logic status_hit;

	////////////////////////////////////////////////////////////
	// write channel.
	////////////////////////////////////////////////////////////

	// address and data are taken together, never while a response waits.
	assign awready = awvalid && wvalid && !bvalid;
	assign wready  = awready;

	// the instruction needs its low half fully written.
	assign instr_hit   = (awaddr == addr_instr) && (wstrb[1:0] == 2'b11);
	assign instr_valid = awready && instr_hit;
	assign instr       = wdata[15:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			bvalid <= 1'b0;
		else if (awready)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (awready)
			bresp <= instr_hit ? axil_resp_okay : axil_resp_slverr;
	end

	////////////////////////////////////////////////////////////
	// read channel.
	////////////////////////////////////////////////////////////

	assign arready = arvalid && !rvalid;

	// registers sit at 0x20 + 4n.
	assign reg_hit      = (araddr[7:5] == addr_reg_base[7:5]) && (araddr[1:0] == 2'b00);
	assign status_hit   = (araddr == addr_status);
	assign host_rd_addr = araddr[4:2];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rvalid <= 1'b0;
		else if (arready)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (arready) begin
			if (reg_hit) begin
				rdata <= {16'h0000, host_rd_data};
				rresp <= axil_resp_okay;
			end else if (status_hit) begin
				rdata <= status;
				rresp <= axil_resp_okay;
			end else begin
				rdata <= '0;
				rresp <= axil_resp_slverr;
			end
		end
	end

endmodule : lc3b_axil_port

`default_nettype wire

// File: lc3b_core.sv
`default_nettype none

module lc3b_core import lc3b_types::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [7:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [7:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);

	logic        instr_valid;
	lc3b_word    instr;
	lc3b_reg     host_rd_addr;
	lc3b_word    host_rd_data;
	logic [31:0] status;
	lc3b_word    pc;
	lc3b_word    pc_next;
	lc3b_if_id   if_id_in;
	lc3b_if_id   if_id_data;
	logic        if_id_valid;
	lc3b_id_ex   id_ex_in;
	lc3b_id_ex   id_ex_data;
	logic        id_ex_valid;
	lc3b_ex_wb   ex_wb_in;
	lc3b_ex_wb   ex_wb_data;
	logic        ex_wb_valid;
	lc3b_opcode  opcode;
	lc3b_control ctrl;
	lc3b_reg     sr1;
	lc3b_reg     sr2;
	lc3b_word    sr1_rf;
	lc3b_word    sr2_rf;
	lc3b_word    alu_result;
	lc3b_word    ex_result;
	logic        rf_load;
	logic        busy;
	logic [2:0]  nzp;
	logic [7:0]  retired_count;
	logic [7:0]  illegal_count;

	// nearest producer wins, then the register file.
	function automatic lc3b_word forward(input lc3b_reg sel, input lc3b_word rf_value);
		if (id_ex_valid && id_ex_data.ctrl.regfile_load && id_ex_data.dest == sel)
			return ex_result;
		if (ex_wb_valid && ex_wb_data.ctrl.regfile_load && ex_wb_data.dest == sel)
			return ex_wb_data.result;
		return rf_value;
	endfunction

	lc3b_axil_port axil_port_inst (
		.clk, .arst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.instr_valid, .instr, .host_rd_addr, .host_rd_data, .status
	);

	////////////////////////////////////////////////////////////
	// fetch: pc and the if_id stage.
	////////////////////////////////////////////////////////////

	assign pc_next = pc + 16'd2;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= pc_reset;
		else if (instr_valid)
			pc <= pc_next;
	end

	assign if_id_in.instr   = instr;
	assign if_id_in.pc_next = pc_next;

	lc3b_stage_reg #(.payload_t(lc3b_if_id)) if_id (
		.clk, .arst_n,
		.valid_in(instr_valid), .data_in(if_id_in),
		.valid(if_id_valid), .data(if_id_data)
	);

	////////////////////////////////////////////////////////////
	// decode: control word, operands and the lea address.
	////////////////////////////////////////////////////////////

	assign opcode = lc3b_opcode'(if_id_data.instr[15:12]);
	assign sr1    = if_id_data.instr[8:6];
	assign sr2    = if_id_data.instr[2:0];

	lc3b_control_gen control_gen_inst (
		.opcode, .ir_bits(if_id_data.instr[11:0]), .ctrl
	);

	lc3b_regfile regfile_inst (
		.clk, .arst_n,
		.load(rf_load), .dest(ex_wb_data.dest), .wdata(ex_wb_data.result),
		.sr1, .sr2, .host_sel(host_rd_addr),
		.sr1_data(sr1_rf), .sr2_data(sr2_rf), .host_data(host_rd_data)
	);

	always_comb begin
		id_ex_in.ctrl  = ctrl;
		id_ex_in.dest  = if_id_data.instr[11:9];
		id_ex_in.a     = forward(sr1, sr1_rf);
		id_ex_in.b     = forward(sr2, sr2_rf);
		id_ex_in.imm   = {{11{if_id_data.instr[4]}}, if_id_data.instr[4:0]};
		id_ex_in.shamt = if_id_data.instr[3:0];
		// pc+2 plus the word offset.
		id_ex_in.lea_addr = if_id_data.pc_next +
			{{6{if_id_data.instr[8]}}, if_id_data.instr[8:0], 1'b0};
	end

	lc3b_stage_reg #(.payload_t(lc3b_id_ex)) id_ex (
		.clk, .arst_n,
		.valid_in(if_id_valid), .data_in(id_ex_in),
		.valid(id_ex_valid), .data(id_ex_data)
	);

	// execute.
	lc3b_alu alu_inst (
		.aluop(id_ex_data.ctrl.aluop), .alumux_sel(id_ex_data.ctrl.alumux_sel),
		.a(id_ex_data.a), .b(id_ex_data.b), .imm(id_ex_data.imm),
		.shamt(id_ex_data.shamt), .result(alu_result)
	);

	assign ex_result = (id_ex_data.ctrl.wbmux_sel == wb_lea) ? id_ex_data.lea_addr : alu_result;

	assign ex_wb_in.ctrl   = id_ex_data.ctrl;
	assign ex_wb_in.dest   = id_ex_data.dest;
	assign ex_wb_in.result = ex_result;

	lc3b_stage_reg #(.payload_t(lc3b_ex_wb)) ex_wb (
		.clk, .arst_n,
		.valid_in(id_ex_valid), .data_in(ex_wb_in),
		.valid(ex_wb_valid), .data(ex_wb_data)
	);

	////////////////////////////////////////////////////////////
	// writeback: condition codes, counters and status.
	////////////////////////////////////////////////////////////

	assign rf_load = ex_wb_valid && ex_wb_data.ctrl.regfile_load;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			nzp           <= 3'b010;
			retired_count <= '0;
			illegal_count <= '0;
		end else if (ex_wb_valid) begin
			if (ex_wb_data.ctrl.cc_load)
				nzp <= {ex_wb_data.result[15], ex_wb_data.result == 16'h0000,
					!ex_wb_data.result[15] && ex_wb_data.result != 16'h0000};
			if (ex_wb_data.ctrl.legal)
				retired_count <= retired_count + 8'd1;
			else
				illegal_count <= illegal_count + 8'd1;
		end
	end

	assign busy   = if_id_valid || id_ex_valid || ex_wb_valid;
	assign status = {8'h00, illegal_count, retired_count, 4'h0, busy, nzp};

endmodule : lc3b_core

`default_nettype wire

// File: lc3b_core_checker.sv
`default_nettype none

module lc3b_core_checker (
	input logic       clk,
	input logic       arst_n,
	input logic       awready,
	input logic       bvalid,
	input logic       bready,
	input logic       rvalid,
	input logic       rready,
	input logic       instr_valid,
	input logic       if_id_valid,
	input logic       id_ex_valid,
	input logic       ex_wb_valid,
	input logic [7:0] retired_count,
	input logic [7:0] illegal_count
);
	timeunit 1ns;
	timeprecision 100ps;

	// read by the testbench at the end of the run.
	int failures = 0;

	////////////////////////////////////////////////////////////
	// axi4-lite handshakes.
	////////////////////////////////////////////////////////////

	bvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			failures++;
		end

	rvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			failures++;
		end

	// an accepted write is answered next cycle and holds off the next one.
	write_answered: assert property (@(posedge clk) disable iff (!arst_n)
		awready |=> bvalid && !awready)
		else begin
			$error("write not answered next cycle or accepted while bvalid pending");
			failures++;
		end

	////////////////////////////////////////////////////////////
	// pipeline.
	////////////////////////////////////////////////////////////

	// the counter update from edge k+3 shows at the tick after it.
	retires_on_time: assert property (@(posedge clk) disable iff (!arst_n)
		$past(instr_valid, 4) |-> {retired_count, illegal_count} !=
			$past({retired_count, illegal_count}))
		else begin
			$error("no counter increment three cycles after issue");
			failures++;
		end

	stages_idle_in_reset: assert property (@(posedge clk)
		!arst_n |-> !(if_id_valid || id_ex_valid || ex_wb_valid))
		else begin
			$error("stage valid high during reset");
			failures++;
		end

endmodule : lc3b_core_checker

bind lc3b_core lc3b_core_checker checker_inst (
	.clk, .arst_n, .awready, .bvalid, .bready, .rvalid, .rready, .instr_valid,
	.if_id_valid, .id_ex_valid, .ex_wb_valid, .retired_count, .illegal_count
);

`default_nettype wire

// File: tb_lc3b_core.sv
`default_nettype none

module tb_lc3b_core import lc3b_types::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int planned_instrs = 64;
	localparam int timeout_cycles = 200 * planned_instrs + 2000;

	logic        clk;
	logic        arst_n;
	logic [7:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [7:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	integer      seed = 32'h9bba;
	int          delay_max;
	logic        hold_ready;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_start;
	lc3b_word    model_regs [8];
	logic [2:0]  model_nzp;
	logic [7:0]  model_retired;
	logic [7:0]  model_illegal;
	lc3b_word    model_pc;

	lc3b_core lc3b_core_inst (
		.clk, .arst_n, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
		.rvalid, .rready
	);

	always #10 clk = ~clk;

	initial begin
		#(timeout_cycles * 20);
		$display("watchdog expired after %0d cycles, the DUT stopped responding", timeout_cycles);
		$display("Done: errors found");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// host side of the axi4-lite port, called at edge + 2 ns.
	////////////////////////////////////////////////////////////

	task automatic ready_wait;
		int n;
		n = (delay_max == 0) ? 0 : {$random(seed)} % (delay_max + 1);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		// address and data are accepted in the same cycle.
		check_value("wready at accept", {31'd0, wready}, 32'd1);
		@(posedge clk);
		#2;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		if (!hold_ready)
			ready_wait();
		bready = 1'b1;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		resp = bresp;
		@(posedge clk);
		#2;
		bready = hold_ready;
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		araddr  = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		#2;
		arvalid = 1'b0;
		ready_wait();
		rready = 1'b1;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		resp = rresp;
		@(posedge clk);
		#2;
		rready = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// reference model from the isa rules.
	////////////////////////////////////////////////////////////

	task automatic model_exec(input lc3b_word instr);
		lc3b_word src1;
		lc3b_word op2;
		lc3b_word value;
		logic     kept;
		model_pc = model_pc + 16'd2;
		src1     = model_regs[instr[8:6]];
		op2      = instr[5] ? 16'($signed(instr[4:0])) : model_regs[instr[2:0]];
		kept     = 1'b1;
		value    = '0;
		case (instr[15:12])
			4'b0001: value = src1 + op2;
			4'b0101: value = src1 & op2;
			4'b1001: value = ~src1;
			4'b1101: begin
				value = instr[4] ? (src1 >> instr[3:0]) : (src1 << instr[3:0]);
				// arithmetic form refills the vacated top bits with the sign.
				if (instr[5:4] == 2'b11 && src1[15])
					value = value | ~(16'hffff >> instr[3:0]);
			end
			4'b1110: value = model_pc + 16'($signed(instr[8:0]) * 2);
			default: kept = 1'b0;
		endcase
		if (kept) begin
			model_regs[instr[11:9]] = value;
			model_nzp     = value[15] ? 3'b100 : (value == 16'h0000) ? 3'b010 : 3'b001;
			model_retired = model_retired + 8'd1;
		end else begin
			model_illegal = model_illegal + 8'd1;
		end
	endtask

	function automatic lc3b_word encode_reg(input lc3b_opcode op, input lc3b_reg dr,
			input lc3b_reg sr1, input lc3b_reg sr2);
		return {op, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic lc3b_word encode_imm(input lc3b_opcode op, input lc3b_reg dr,
			input lc3b_reg sr1, input int imm);
		return {op, dr, sr1, 1'b1, imm[4:0]};
	endfunction

	function automatic lc3b_word encode_not(input lc3b_reg dr, input lc3b_reg sr);
		return {op_not, dr, sr, 6'h3f};
	endfunction

	// mode is {bit 5, bit 4}: 00 left, 01 logical right, 11 arithmetic right.
	function automatic lc3b_word encode_shf(input lc3b_reg dr, input lc3b_reg sr,
			input logic [1:0] mode, input logic [3:0] amt);
		return {op_shf, dr, sr, mode, amt};
	endfunction

	function automatic lc3b_word encode_lea(input lc3b_reg dr, input int off);
		return {op_lea, dr, off[8:0]};
	endfunction

	////////////////////////////////////////////////////////////
	// checks and reporting.
	////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic issue(input lc3b_word instr);
		logic [1:0] resp;
		axil_write(addr_instr, {16'h0000, instr}, resp);
		check_value("instruction bresp", {30'd0, resp}, {30'd0, axil_resp_okay});
		model_exec(instr);
	endtask

	// polls until the pipeline drains, then compares status fields.
	task automatic check_status;
		logic [31:0] data;
		logic [1:0]  resp;
		do
			axil_read(addr_status, data, resp);
		while (data[3] === 1'b1);
		check_value("nzp", {29'd0, data[2:0]}, {29'd0, model_nzp});
		check_value("retired count", {24'd0, data[15:8]}, {24'd0, model_retired});
		check_value("illegal count", {24'd0, data[23:16]}, {24'd0, model_illegal});
	endtask

	task automatic check_all;
		logic [31:0] data;
		logic [1:0]  resp;
		check_status();
		for (int i = 0; i < 8; i++) begin
			axil_read(addr_reg_base + 8'(4 * i), data, resp);
			check_value($sformatf("R%0d", i), data, {16'h0000, model_regs[i]});
			check_value("register rresp", {30'd0, resp}, {30'd0, axil_resp_okay});
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start) begin
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, errors - test_start);
		end
		test_start = errors;
	endtask

	initial begin
		logic [31:0] rnd;
		logic [31:0] data;
		logic [1:0]  resp;
		clk = 1'b0;
		arst_n = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_start = 0;
		delay_max = 2;
		hold_ready = 1'b0;
		for (int i = 0; i < 8; i++)
			model_regs[i] = '0;
		model_nzp = 3'b010;
		model_retired = '0;
		model_illegal = '0;
		model_pc = pc_reset;
		#1 arst_n = 1'b0;
		repeat (8) @(posedge clk);
		#2 arst_n = 1'b1;

		issue(encode_imm(op_add, 3'd1, 3'd0, 7));
		issue(encode_imm(op_add, 3'd2, 3'd0, -5));
		issue(encode_reg(op_add, 3'd3, 3'd1, 3'd2));
		issue(encode_imm(op_and, 3'd4, 3'd2, -4));
		issue(encode_reg(op_and, 3'd5, 3'd1, 3'd2));
		issue(encode_imm(op_add, 3'd6, 3'd3, -16));
		check_all();
		end_test("add_and");

		issue(encode_not(3'd7, 3'd2));
		issue(encode_shf(3'd1, 3'd2, 2'b00, 4'd3));
		issue(encode_shf(3'd3, 3'd2, 2'b01, 4'd2));
		issue(encode_shf(3'd4, 3'd2, 2'b11, 4'd2));
		issue(encode_shf(3'd5, 3'd7, 2'b11, 4'd1));
		check_all();
		end_test("not_shf");

		// bready high so each write follows the last as fast as the port allows.
		hold_ready = 1'b1;
		delay_max = 0;
		issue(encode_imm(op_add, 3'd1, 3'd0, 3));
		issue(encode_imm(op_add, 3'd1, 3'd1, 4));
		issue(encode_imm(op_add, 3'd2, 3'd1, -1));
		issue(encode_reg(op_add, 3'd3, 3'd1, 3'd2));
		issue(encode_reg(op_and, 3'd4, 3'd1, 3'd3));
		issue(encode_not(3'd5, 3'd2));
		hold_ready = 1'b0;
		bready = 1'b0;
		delay_max = 2;
		check_all();
		end_test("forwarding");

		issue(encode_imm(op_and, 3'd1, 3'd1, 0));
		check_status();
		issue(encode_imm(op_add, 3'd2, 3'd0, -1));
		check_status();
		issue(encode_lea(3'd3, 10));
		check_status();
		issue(encode_lea(3'd4, -3));
		check_all();
		end_test("nzp_lea");

		// branch, load and trap opcodes.
		issue(16'h0e05);
		issue(16'h6283);
		issue(16'hf025);
		check_all();
		axil_write(8'h08, 32'h0000_1234, resp);
		check_value("unmapped bresp", {30'd0, resp}, {30'd0, axil_resp_slverr});
		axil_read(8'h10, data, resp);
		check_value("unmapped rdata", data, 32'h0);
		check_value("unmapped rresp", {30'd0, resp}, {30'd0, axil_resp_slverr});
		axil_read(addr_instr, data, resp);
		check_value("instr read rresp", {30'd0, resp}, {30'd0, axil_resp_slverr});
		end_test("illegal_unmapped");

		delay_max = 3;
		for (int n = 0; n < 40; n++) begin
			rnd = $random(seed);
			case (rnd[31:29])
				3'd0, 3'd1: issue({op_add, rnd[11:0]});
				3'd2, 3'd3: issue({op_and, rnd[11:0]});
				3'd4:       issue(encode_not(rnd[11:9], rnd[8:6]));
				3'd5, 3'd6: issue({op_shf, rnd[11:0]});
				default:    issue({op_lea, rnd[11:0]});
			endcase
		end
		check_all();
		end_test("random");

		repeat (5) @(posedge clk);
		$display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, errors, lc3b_core_inst.checker_inst.failures);
		if (errors == 0 && tests_failed == 0 && lc3b_core_inst.checker_inst.failures == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule : tb_lc3b_core

`default_nettype wire

// File: list.f
lc3b_types.sv
lc3b_control_gen.sv
lc3b_stage_reg.sv
lc3b_regfile.sv
lc3b_alu.sv
lc3b_axil_port.sv
lc3b_core.sv
lc3b_core_checker.sv
tb_lc3b_core.sv

// File: Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_lc3b_core
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
